// ==== hdl/fwrisc_fetch_pkg.sv ====
// shared widths, major opcodes and the memory word view for the fetch unit
// memory words are little endian, so the low parcel is the even halfword

package fwrisc_fetch_pkg;

  // data and address width
  localparam int XLEN = 32;

  // one instruction parcel
  localparam int PARCEL_W = 16;

  // major opcodes produced by the compressed expander
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
  localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
  localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
  localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
  localparam logic [6:0] OPCODE_STORE  = 7'b0100011;

  // one fetched memory word
  // read as a whole 32-bit instruction or as two parcels
  // parcel[0] sits at the even halfword, parcel[1] at the odd one
  typedef union packed {
    logic [XLEN-1:0]                instr;
    logic [1:0][PARCEL_W-1:0]       parcel;
  } fetch_word_u;

endpackage

// ==== hdl/fwrisc_c_decode.sv ====
// purely combinational RVC expander, no legality or RV32E register checks
// unsupported compressed encodings expand to 32'h0, quadrant 11 passes through
`timescale 1ns/1ps

module fwrisc_c_decode (
  input  logic [fwrisc_fetch_pkg::XLEN-1:0] instr_i,
  output logic [fwrisc_fetch_pkg::XLEN-1:0] instr_o
);
  import fwrisc_fetch_pkg::*;

  // compressed parcel, only meaningful when quadrant != 11
  logic [PARCEL_W-1:0] c;

  assign c = instr_i[PARCEL_W-1:0];

  always_comb begin
    // anything not matched below stays zero
    instr_o = '0;
    case (c[1:0])
      // quadrant 0, stack and register-relative memory ops
      2'b00: begin
        case (c[15:13])
          // c.addi4spn, addi rd', x2, nzuimm
          3'b000: instr_o = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00, 5'd2, 3'b000,
                             2'b01, c[4:2], OPCODE_OP_IMM};
          // c.lw, lw rd', off(rs1')
          3'b010: instr_o = {5'b0, c[5], c[12:10], c[6], 2'b00, 2'b01, c[9:7], 3'b010,
                             2'b01, c[4:2], OPCODE_LOAD};
          // c.sw, sw rs2', off(rs1')
          3'b110: instr_o = {5'b0, c[5], c[12], 2'b01, c[4:2], 2'b01, c[9:7], 3'b010,
                             c[11:10], c[6], 2'b00, OPCODE_STORE};
          default: instr_o = '0;
        endcase
      end

      // quadrant 1, immediates, jumps, branches and register ALU ops
      2'b01: begin
        case (c[15:13])
          // c.addi and c.nop
          3'b000: instr_o = {{6{c[12]}}, c[12], c[6:2], c[11:7], 3'b000, c[11:7],
                             OPCODE_OP_IMM};
          // c.jal links x1, c.j links x0, rd[0] comes from ~c[15]
          3'b001, 3'b101: instr_o = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                                     {9{c[12]}}, 4'b0000, ~c[15], OPCODE_JAL};
          // c.li, addi rd, x0, imm
          3'b010: instr_o = {{6{c[12]}}, c[12], c[6:2], 5'd0, 3'b000, c[11:7], OPCODE_OP_IMM};
          3'b011: begin
            if (c[11:7] == 5'd2) begin
              // rd of x2 turns c.lui into c.addi16sp
              instr_o = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000, 5'd2, 3'b000, 5'd2,
                         OPCODE_OP_IMM};
            end else begin
              // c.lui, imm lands in bits 17:12
              instr_o = {{15{c[12]}}, c[6:2], c[11:7], OPCODE_LUI};
            end
          end
          3'b100: begin
            case (c[11:10])
              // c.srli / c.srai, c[10] picks arithmetic
              2'b00, 2'b01: instr_o = {1'b0, c[10], 5'b0, c[6:2], 2'b01, c[9:7], 3'b101,
                                       2'b01, c[9:7], OPCODE_OP_IMM};
              // c.andi
              2'b10: instr_o = {{6{c[12]}}, c[12], c[6:2], 2'b01, c[9:7], 3'b111,
                                2'b01, c[9:7], OPCODE_OP_IMM};
              // register-register group, c[12] set is not RV32
              default: begin
                case ({c[12], c[6:5]})
                  // c.sub
                  3'b000: instr_o = {7'b0100000, 2'b01, c[4:2], 2'b01, c[9:7], 3'b000,
                                     2'b01, c[9:7], OPCODE_OP};
                  // c.xor
                  3'b001: instr_o = {7'b0, 2'b01, c[4:2], 2'b01, c[9:7], 3'b100,
                                     2'b01, c[9:7], OPCODE_OP};
                  // c.or
                  3'b010: instr_o = {7'b0, 2'b01, c[4:2], 2'b01, c[9:7], 3'b110,
                                     2'b01, c[9:7], OPCODE_OP};
                  // c.and
                  3'b011: instr_o = {7'b0, 2'b01, c[4:2], 2'b01, c[9:7], 3'b111,
                                     2'b01, c[9:7], OPCODE_OP};
                  default: instr_o = '0;
                endcase
              end
            endcase
          end
          // c.beqz / c.bnez against x0, c[13] becomes funct3[0]
          3'b110, 3'b111: instr_o = {{4{c[12]}}, c[6:5], c[2], 5'd0, 2'b01, c[9:7], 2'b00,
                                     c[13], c[11:10], c[4:3], c[12], OPCODE_BRANCH};
          default: instr_o = '0;
        endcase
      end

      // quadrant 2, sp-relative memory ops, moves and register jumps
      2'b10: begin
        case (c[15:13])
          // c.slli
          3'b000: instr_o = {7'b0, c[6:2], c[11:7], 3'b001, c[11:7], OPCODE_OP_IMM};
          // c.lwsp, lw rd, off(x2)
          3'b010: instr_o = {4'b0, c[3:2], c[12], c[6:4], 2'b00, 5'd2, 3'b010, c[11:7],
                             OPCODE_LOAD};
          3'b100: begin
            // c[12] splits mv/jr from add/jalr/ebreak
            if (!c[12]) begin
              if (c[6:2] != 5'd0) begin
                // c.mv, add rd, x0, rs2
                instr_o = {7'b0, c[6:2], 5'd0, 3'b000, c[11:7], OPCODE_OP};
              end else begin
                // c.jr, jalr x0, 0(rs1)
                instr_o = {12'd0, c[11:7], 3'b000, 5'd0, OPCODE_JALR};
              end
            end else if (c[6:2] != 5'd0) begin
              // c.add, add rd, rd, rs2
              instr_o = {7'b0, c[6:2], c[11:7], 3'b000, c[11:7], OPCODE_OP};
            end else if (c[11:7] == 5'd0) begin
              // c.ebreak
              instr_o = 32'h0010_0073;
            end else begin
              // c.jalr, jalr x1, 0(rs1)
              instr_o = {12'd0, c[11:7], 3'b000, 5'd1, OPCODE_JALR};
            end
          end
          // c.swsp, sw rs2, off(x2)
          3'b110: instr_o = {4'b0, c[8:7], c[12], c[6:2], 5'd2, 3'b010, c[11:9], 2'b00,
                             OPCODE_STORE};
          default: instr_o = '0;
        endcase
      end

      // full 32-bit instruction
      default: instr_o = instr_i;
    endcase
  end

endmodule

// ==== hdl/fwrisc_fetch_fsm.sv ====
// sequences one or two word fetches per instruction, one request in flight
// straddle_i is only sampled in the cycle the first word returns
`timescale 1ns/1ps

module fwrisc_fetch_fsm (
  input  logic clock,
  input  logic arst_n_i,
  input  logic next_i,
  input  logic jump_i,
  input  logic imem_rvalid_i,
  input  logic straddle_i,
  output logic busy_o,
  output logic imem_req_o,
  output logic second_word_o,
  output logic word_sel_o,
  output logic instr_valid_o,
  output logic pc_load_o,
  output logic pc_inc_o
);

  localparam logic [2:0] S_IDLE    = 3'd0;
  localparam logic [2:0] S_REQ_LO  = 3'd1;
  localparam logic [2:0] S_WAIT_LO = 3'd2;
  localparam logic [2:0] S_REQ_HI  = 3'd3;
  localparam logic [2:0] S_WAIT_HI = 3'd4;
  localparam logic [2:0] S_DELIVER = 3'd5;

  logic [2:0] state_q;
  logic [2:0] state_d;

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:    if (next_i) state_d = S_REQ_LO;
      // request strobe is a single cycle
      S_REQ_LO:  state_d = S_WAIT_LO;
      S_WAIT_LO: begin
        // aligner looks at the arriving word to spot a 32-bit op at the odd half
        if (imem_rvalid_i) begin
          state_d = straddle_i ? S_REQ_HI : S_DELIVER;
        end
      end
      S_REQ_HI:  state_d = S_WAIT_HI;
      S_WAIT_HI: if (imem_rvalid_i) state_d = S_DELIVER;
      S_DELIVER: state_d = S_IDLE;
      default:   state_d = S_IDLE;
    endcase
  end

  // busy covers the delivery cycle too
  assign busy_o        = (state_q != S_IDLE);
  assign imem_req_o    = (state_q == S_REQ_LO) || (state_q == S_REQ_HI);
  // top level bumps the word address for this request
  assign second_word_o = (state_q == S_REQ_HI);
  // steers the returning word into the high holding register
  assign word_sel_o    = (state_q == S_WAIT_HI);
  assign instr_valid_o = (state_q == S_DELIVER);
  // pc moves after the delivery cycle so instr_pc_o still shows the old pc
  assign pc_inc_o      = (state_q == S_DELIVER);
  // jumps only land while idle, a same-cycle next_i then fetches the target
  assign pc_load_o     = jump_i && (state_q == S_IDLE);

  // core keeps to the busy protocol
  a_next_not_busy: assert property (@(posedge clock) disable iff (!arst_n_i)
    next_i |-> !busy_o);

  a_jump_not_busy: assert property (@(posedge clock) disable iff (!arst_n_i)
    jump_i |-> !busy_o);

  // memory answers only a request that is still open
  a_rvalid_outstanding: assert property (@(posedge clock) disable iff (!arst_n_i)
    imem_rvalid_i |-> (state_q == S_WAIT_LO) || (state_q == S_WAIT_HI));

endmodule

// ==== hdl/fwrisc_pc_counter.sv ====
// program counter, jump load wins over increment
// RESET_PC and every jump target must be halfword aligned
`timescale 1ns/1ps

module fwrisc_pc_counter #(
  parameter logic [fwrisc_fetch_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                              clock,
  input  logic                              arst_n_i,
  input  logic                              load_i,
  input  logic [fwrisc_fetch_pkg::XLEN-1:0] jump_addr_i,
  input  logic                              inc_i,
  input  logic                              is_c_i,
  output logic [fwrisc_fetch_pkg::XLEN-1:0] pc_o
);
  import fwrisc_fetch_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] step;

  // compressed ops advance one parcel, others two
  assign step = is_c_i ? XLEN'(2) : XLEN'(4);

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q <= RESET_PC;
    end else if (load_i) begin
      pc_q <= jump_addr_i;
    end else if (inc_i) begin
      pc_q <= pc_q + step;
    end
  end

  assign pc_o = pc_q;

  // odd byte addresses would break the parcel select in the aligner
  a_pc_aligned: assert property (@(posedge clock) disable iff (!arst_n_i)
    !pc_q[0]);

endmodule

// ==== hdl/fwrisc_instr_align.sv ====
// holds the fetched words and extracts the raw instruction at pc bit 1
// straddle_o uses the arriving word while the first fetch returns
`timescale 1ns/1ps

module fwrisc_instr_align (
  input  logic                              clock,
  input  logic                              arst_n_i,
  input  logic                              rvalid_i,
  input  logic [fwrisc_fetch_pkg::XLEN-1:0] rdata_i,
  input  logic                              word_sel_i,
  input  logic                              half_i,
  output logic [fwrisc_fetch_pkg::XLEN-1:0] raw_instr_o,
  output logic                              raw_is_c_o,
  output logic                              straddle_o
);
  import fwrisc_fetch_pkg::*;

  fetch_word_u         rdata_w;
  fetch_word_u         word_lo_q;
  fetch_word_u         word_hi_q;
  fetch_word_u         lo_view;
  logic [PARCEL_W-1:0] sel_parcel;

  assign rdata_w = rdata_i;

  // word_sel_i low captures the word at the pc, high the word after it
  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      word_lo_q <= '0;
      word_hi_q <= '0;
    end else if (rvalid_i) begin
      if (word_sel_i) begin
        word_hi_q <= rdata_w;
      end else begin
        word_lo_q <= rdata_w;
      end
    end
  end

  // fsm decides on the rvalid edge, so look through to the bus then
  assign lo_view = (rvalid_i && !word_sel_i) ? rdata_w : word_lo_q;

  // 32-bit op starting at the odd half needs the next word
  assign straddle_o = half_i && (lo_view.parcel[1][1:0] == 2'b11);

  always_comb begin
    if (!half_i) begin
      sel_parcel  = word_lo_q.parcel[0];
      raw_instr_o = word_lo_q.instr;
    end else begin
      // odd half, the upper parcel comes from the second word
      sel_parcel  = word_lo_q.parcel[1];
      raw_instr_o = {word_hi_q.parcel[0], word_lo_q.parcel[1]};
    end
    // a compressed parcel is zero extended for the expander
    if (sel_parcel[1:0] != 2'b11) begin
      raw_instr_o = {{(XLEN-PARCEL_W){1'b0}}, sel_parcel};
    end
  end

  // quadrants 00, 01 and 10 are compressed
  assign raw_is_c_o = (sel_parcel[1:0] != 2'b11);

endmodule

// ==== hdl/fwrisc_fetch.sv ====
// instruction fetch front end, one memory request outstanding, no prefetch
// memory must answer each imem_req_o with exactly one imem_rvalid_i
`timescale 1ns/1ps

module fwrisc_fetch #(
  parameter logic [fwrisc_fetch_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                              clock,
  input  logic                              arst_n_i,
  // core side
  input  logic                              next_i,
  input  logic                              jump_i,
  input  logic [fwrisc_fetch_pkg::XLEN-1:0] jump_addr_i,
  output logic                              busy_o,
  output logic                              instr_valid_o,
  output logic [fwrisc_fetch_pkg::XLEN-1:0] instr_o,
  output logic [fwrisc_fetch_pkg::XLEN-1:0] instr_pc_o,
  output logic                              instr_is_c_o,
  // memory side
  output logic                              imem_req_o,
  output logic [fwrisc_fetch_pkg::XLEN-1:0] imem_addr_o,
  input  logic                              imem_rvalid_i,
  input  logic [fwrisc_fetch_pkg::XLEN-1:0] imem_rdata_i
);
  import fwrisc_fetch_pkg::*;

  logic            pc_load;
  logic            pc_inc;
  logic            second_word;
  logic            word_sel;
  logic            straddle;
  logic            raw_is_c;
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] raw_instr;

  fwrisc_fetch_fsm u_fsm (
    .clock         (clock),
    .arst_n_i      (arst_n_i),
    .next_i        (next_i),
    .jump_i        (jump_i),
    .imem_rvalid_i (imem_rvalid_i),
    .straddle_i    (straddle),
    .busy_o        (busy_o),
    .imem_req_o    (imem_req_o),
    .second_word_o (second_word),
    .word_sel_o    (word_sel),
    .instr_valid_o (instr_valid_o),
    .pc_load_o     (pc_load),
    .pc_inc_o      (pc_inc)
  );

  fwrisc_pc_counter #(
    .RESET_PC (RESET_PC)
  ) u_pc (
    .clock       (clock),
    .arst_n_i    (arst_n_i),
    .load_i      (pc_load),
    .jump_addr_i (jump_addr_i),
    .inc_i       (pc_inc),
    .is_c_i      (raw_is_c),
    .pc_o        (pc)
  );

  // word address of the pc, or the following word for a straddling op
  assign imem_addr_o = {pc[XLEN-1:2] + (XLEN-2)'(second_word), 2'b00};

  fwrisc_instr_align u_align (
    .clock       (clock),
    .arst_n_i    (arst_n_i),
    .rvalid_i    (imem_rvalid_i),
    .rdata_i     (imem_rdata_i),
    .word_sel_i  (word_sel),
    .half_i      (pc[1]),
    .raw_instr_o (raw_instr),
    .raw_is_c_o  (raw_is_c),
    .straddle_o  (straddle)
  );

  fwrisc_c_decode u_c_decode (
    .instr_i (raw_instr),
    .instr_o (instr_o)
  );

  // pc only moves after the delivery cycle
  assign instr_pc_o   = pc;
  assign instr_is_c_o = raw_is_c;

endmodule

// ==== tests/fwrisc_fetch_clkgen.sv ====
// free running clock and power-on reset for the fetch testbench
// reset is released on a falling edge after RESET_CYCLES rising edges
`timescale 1ns/1ps

module fwrisc_fetch_clkgen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 10
) (
  output logic clock_o,
  output logic arst_n_o
);

  initial begin
    clock_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clock_o = ~clock_o;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock_o);
    // release away from the rising edge
    @(negedge clock_o);
    arst_n_o = 1'b1;
  end

endmodule

// ==== tests/fwrisc_fetch_tb.sv ====
// random program fetch test against a 256-word memory that wraps
// memory answers each read after 1 to 4 cycles
// the reference expander skips legality checks just as the DUT does
`timescale 1ns/1ps

module fwrisc_fetch_tb;
  import fwrisc_fetch_pkg::*;

  // odd halfword start so the first op may straddle
  localparam logic [XLEN-1:0] RESET_PC     = 32'h0000_0106;
  localparam int              RESET_CYCLES = 10;
  localparam int              N_INSTR      = 2000;
  localparam int              TIMEOUT      = RESET_CYCLES + N_INSTR * 12;
  // two fetches at the longest delay fit well inside this
  localparam int              DELIVER_MAX  = 24;

  logic            clock;
  logic            arst_n;
  logic            next;
  logic            jump;
  logic [XLEN-1:0] jump_addr;
  logic            busy;
  logic            instr_valid;
  logic [XLEN-1:0] instr;
  logic [XLEN-1:0] instr_pc;
  logic            instr_is_c;
  logic            imem_req;
  logic [XLEN-1:0] imem_addr;
  logic            imem_rvalid;
  logic [XLEN-1:0] imem_rdata;

  fetch_word_u     imem [0:255];
  logic [31:0]     lfsr_state;
  int              value_errors;
  int              protocol_errors;
  int              cycle_count;

  fwrisc_fetch_clkgen #(
    .PERIOD_NS    (4),
    .RESET_CYCLES (RESET_CYCLES)
  ) u_clkgen (
    .clock_o  (clock),
    .arst_n_o (arst_n)
  );

  fwrisc_fetch #(
    .RESET_PC (RESET_PC)
  ) UUT (
    .clock         (clock),
    .arst_n_i      (arst_n),
    .next_i        (next),
    .jump_i        (jump),
    .jump_addr_i   (jump_addr),
    .busy_o        (busy),
    .instr_valid_o (instr_valid),
    .instr_o       (instr),
    .instr_pc_o    (instr_pc),
    .instr_is_c_o  (instr_is_c),
    .imem_req_o    (imem_req),
    .imem_addr_o   (imem_addr),
    .imem_rvalid_i (imem_rvalid),
    .imem_rdata_i  (imem_rdata)
  );

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per returned bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    take_bits = r;
  endfunction

  // mostly compressed parcels steered toward supported funct3 values
  function automatic logic [PARCEL_W-1:0] random_parcel();
    logic [PARCEL_W-1:0] p;
    logic [1:0]          q;
    p = 16'(take_bits(16));
    q = 2'(take_bits(2));
    // half of the 11 draws fold back into quadrant 0 or 1
    if (q == 2'b11 && take_bits(1) != 0) begin
      q = 2'(take_bits(1));
    end
    if (q == 2'b00) begin
      case (take_bits(2))
        0: p[15:13] = 3'b000;
        1: p[15:13] = 3'b010;
        2: p[15:13] = 3'b110;
        default: ;
      endcase
    end else if (q == 2'b10 && take_bits(2) != 0) begin
      // quadrant 2 only decodes even funct3
      p[13] = 1'b0;
    end
    p[1:0] = q;
    random_parcel = p;
  endfunction

  function automatic logic [PARCEL_W-1:0] parcel_at(input logic [XLEN-1:0] addr);
    parcel_at = imem[addr[9:2]].parcel[addr[1]];
  endfunction

  // base instruction formats
  function automatic logic [XLEN-1:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] op);
    enc_i = {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [XLEN-1:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1);
    enc_s = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPCODE_STORE};
  endfunction

  function automatic logic [XLEN-1:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
    enc_r = {f7, rs2, rs1, f3, rd, OPCODE_OP};
  endfunction

  // reference RVC expansion built from the immediate scrambles of the compressed table
  function automatic logic [XLEN-1:0] expand_c(input logic [PARCEL_W-1:0] p);
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  rdp;
    logic [4:0]  rs1p;
    logic [11:0] imm6;
    logic [20:0] joff;
    logic [12:0] boff;
    rd   = p[11:7];
    rs2  = p[6:2];
    rdp  = {2'b01, p[4:2]};
    rs1p = {2'b01, p[9:7]};
    imm6 = {{7{p[12]}}, p[6:2]};
    expand_c = '0;
    case ({p[1:0], p[15:13]})
      // addi4spn, lw, sw
      5'b00_000: expand_c = enc_i({2'b00, p[10:7], p[12:11], p[5], p[6], 2'b00}, 5'd2,
                                  3'b000, rdp, OPCODE_OP_IMM);
      5'b00_010: expand_c = enc_i({5'b0, p[5], p[12:10], p[6], 2'b00}, rs1p, 3'b010, rdp,
                                  OPCODE_LOAD);
      5'b00_110: expand_c = enc_s({5'b0, p[5], p[12:10], p[6], 2'b00}, rdp, rs1p);
      5'b01_000: expand_c = enc_i(imm6, rd, 3'b000, rd, OPCODE_OP_IMM);
      5'b01_001, 5'b01_101: begin
        // offset bits 11|4|9:8|10|6|7|3:1|5
        joff = {{10{p[12]}}, p[8], p[10:9], p[6], p[7], p[2], p[11], p[5:3], 1'b0};
        expand_c = {joff[20], joff[10:1], joff[11], joff[19:12], p[15] ? 5'd0 : 5'd1,
                    OPCODE_JAL};
      end
      5'b01_010: expand_c = enc_i(imm6, 5'd0, 3'b000, rd, OPCODE_OP_IMM);
      5'b01_011: begin
        if (rd == 5'd2) begin
          expand_c = enc_i({{3{p[12]}}, p[4:3], p[5], p[2], p[6], 4'b0000}, 5'd2, 3'b000,
                           5'd2, OPCODE_OP_IMM);
        end else begin
          expand_c = {{8{imm6[11]}}, imm6, rd, OPCODE_LUI};
        end
      end
      5'b01_100: begin
        case (p[11:10])
          2'b00: expand_c = enc_i({7'b0, rs2}, rs1p, 3'b101, rs1p, OPCODE_OP_IMM);
          2'b01: expand_c = enc_i({7'b0100000, rs2}, rs1p, 3'b101, rs1p, OPCODE_OP_IMM);
          2'b10: expand_c = enc_i(imm6, rs1p, 3'b111, rs1p, OPCODE_OP_IMM);
          default: begin
            // sub, xor, or, and
            if (!p[12]) begin
              case (p[6:5])
                2'b00: expand_c = enc_r(7'b0100000, rdp, rs1p, 3'b000, rs1p);
                2'b01: expand_c = enc_r(7'b0, rdp, rs1p, 3'b100, rs1p);
                2'b10: expand_c = enc_r(7'b0, rdp, rs1p, 3'b110, rs1p);
                default: expand_c = enc_r(7'b0, rdp, rs1p, 3'b111, rs1p);
              endcase
            end
          end
        endcase
      end
      5'b01_110, 5'b01_111: begin
        boff = {{5{p[12]}}, p[6:5], p[2], p[11:10], p[4:3], 1'b0};
        expand_c = {boff[12], boff[10:5], 5'd0, rs1p, 2'b00, p[13], boff[4:1], boff[11],
                    OPCODE_BRANCH};
      end
      5'b10_000: expand_c = enc_i({7'b0, rs2}, rd, 3'b001, rd, OPCODE_OP_IMM);
      5'b10_010: expand_c = enc_i({4'b0, p[3:2], p[12], p[6:4], 2'b00}, 5'd2, 3'b010, rd,
                                  OPCODE_LOAD);
      5'b10_100: begin
        if (!p[12]) begin
          expand_c = (rs2 != 5'd0) ? enc_r(7'b0, rs2, 5'd0, 3'b000, rd)
                                   : enc_i(12'd0, rd, 3'b000, 5'd0, OPCODE_JALR);
        end else if (rs2 != 5'd0) begin
          expand_c = enc_r(7'b0, rs2, rd, 3'b000, rd);
        end else if (rd == 5'd0) begin
          // ebreak
          expand_c = 32'h0010_0073;
        end else begin
          expand_c = enc_i(12'd0, rd, 3'b000, 5'd1, OPCODE_JALR);
        end
      end
      5'b10_110: expand_c = enc_s({4'b0, p[8:7], p[12:9], 2'b00}, rs2, 5'd2);
      default: expand_c = '0;
    endcase
  endfunction

  task automatic check_instr(input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
    if (act !== exp) begin
      value_errors++;
      $display("Error at time %0t: instr_o expected %h, got %h", $time, exp, act);
    end
  endtask

  task automatic check_pc(input string name, input logic [XLEN-1:0] exp,
                          input logic [XLEN-1:0] act);
    if (act !== exp) begin
      value_errors++;
      $display("Error at time %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_is_c(input logic exp, input logic act);
    if (act !== exp) begin
      value_errors++;
      $display("Error at time %0t: instr_is_c_o expected %b, got %b", $time, exp, act);
    end
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errors++;
      $display("Error at time %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < TIMEOUT) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("Timeout, the test did not finish within %0d cycles", TIMEOUT);
    $display("Regression failed");
    $finish;
  end

  initial begin : stimulus
    logic [XLEN-1:0]     model_pc;
    logic [XLEN-1:0]     exp_pc;
    logic [XLEN-1:0]     exp_instr;
    logic [XLEN-1:0]     req_addr;
    logic [PARCEL_W-1:0] lo_parcel;
    logic                exp_is_c;
    logic                pending;
    logic                mem_busy;
    logic                first_cmd;
    logic                abort;
    int                  mem_delay;
    int                  req_count;
    int                  exp_reqs;
    int                  wait_cycles;
    int                  delivered;
    int                  i;
    next            = 1'b0;
    jump            = 1'b0;
    jump_addr       = '0;
    imem_rvalid     = 1'b0;
    imem_rdata      = '0;
    lfsr_state      = 32'h4d77;
    value_errors    = 0;
    protocol_errors = 0;
    for (i = 0; i < 256; i++) begin
      imem[i].parcel[0] = random_parcel();
      imem[i].parcel[1] = random_parcel();
    end
    model_pc    = RESET_PC;
    exp_pc      = '0;
    req_addr    = '0;
    pending     = 1'b0;
    mem_busy    = 1'b0;
    first_cmd   = 1'b1;
    abort       = 1'b0;
    mem_delay   = 0;
    req_count   = 0;
    exp_reqs    = 0;
    wait_cycles = 0;
    delivered   = 0;
    @(posedge arst_n);
    @(negedge clock);
    check_level("imem_req_o", 1'b0, imem_req);
    check_level("instr_valid_o", 1'b0, instr_valid);
    check_level("busy_o", 1'b0, busy);
    while (delivered < N_INSTR && !abort) begin
      @(negedge clock);
      // outputs settle after the rising edge so sample them before driving
      next        = 1'b0;
      jump        = 1'b0;
      imem_rvalid = 1'b0;
      // busy from the accepted next_i through the delivery cycle
      check_level("busy_o", pending, busy);
      // memory model with one word in flight
      if (mem_busy) begin
        mem_delay--;
        if (mem_delay == 0) begin
          imem_rvalid = 1'b1;
          imem_rdata  = imem[req_addr[9:2]].instr;
          mem_busy    = 1'b0;
        end
      end
      if (imem_req) begin
        if (mem_busy) begin
          protocol_errors++;
          $display("imem_req_o pulsed at time %0t while a read was still open", $time);
        end else if (!pending || req_count >= exp_reqs) begin
          protocol_errors++;
          $display("unexpected imem_req_o at time %0t for pc %h", $time, exp_pc);
        end else begin
          // second request goes to the following word
          check_pc("imem_addr_o", {exp_pc[XLEN-1:2], 2'b00} + XLEN'(4 * req_count), imem_addr);
          req_addr  = imem_addr;
          req_count++;
          mem_delay = 1 + int'(take_bits(2));
          mem_busy  = 1'b1;
        end
      end
      if (instr_valid) begin
        if (!pending) begin
          protocol_errors++;
          $display("instr_valid_o pulsed at time %0t with no next_i pending", $time);
        end else begin
          lo_parcel = parcel_at(exp_pc);
          exp_is_c  = (lo_parcel[1:0] != 2'b11);
          if (exp_is_c) begin
            exp_instr = expand_c(lo_parcel);
          end else begin
            exp_instr = {parcel_at(exp_pc + XLEN'(2)), lo_parcel};
          end
          check_instr(exp_instr, instr);
          check_pc("instr_pc_o", exp_pc, instr_pc);
          check_is_c(exp_is_c, instr_is_c);
          if (req_count != exp_reqs) begin
            protocol_errors++;
            $display("instruction at %h came after %0d memory reads instead of %0d",
                     exp_pc, req_count, exp_reqs);
          end
          model_pc = exp_pc + (exp_is_c ? XLEN'(2) : XLEN'(4));
          pending  = 1'b0;
          delivered++;
        end
      end else if (pending) begin
        wait_cycles++;
        if (wait_cycles > DELIVER_MAX) begin
          protocol_errors++;
          $display("no instr_valid_o within %0d cycles of next_i for pc %h",
                   DELIVER_MAX, exp_pc);
          abort = 1'b1;
        end
      end
      // core side issues new commands only while the unit is idle
      if (!pending && !busy && !abort) begin
        if (!first_cmd && take_bits(4) == 0) begin
          // redirect that sometimes lands in the same cycle as next_i
          jump      = 1'b1;
          jump_addr = take_bits(31) << 1;
          model_pc  = jump_addr;
          next      = (take_bits(1) != 0);
        end else begin
          next = (take_bits(3) != 0);
        end
        if (next) begin
          first_cmd   = 1'b0;
          pending     = 1'b1;
          exp_pc      = model_pc;
          lo_parcel   = parcel_at(model_pc);
          exp_reqs    = (model_pc[1] && lo_parcel[1:0] == 2'b11) ? 2 : 1;
          req_count   = 0;
          wait_cycles = 0;
        end
      end
    end
    repeat (4) @(negedge clock);
    $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== fwrisc_fetch.f ====
hdl/fwrisc_fetch_pkg.sv
hdl/fwrisc_c_decode.sv
hdl/fwrisc_fetch_fsm.sv
hdl/fwrisc_pc_counter.sv
hdl/fwrisc_instr_align.sv
hdl/fwrisc_fetch.sv
tests/fwrisc_fetch_clkgen.sv
tests/fwrisc_fetch_tb.sv
